// ==== files.f ====
+incdir+include
source/osd_pkg.sv
source/osd_wb_regs.sv
source/osd_raster.sv
source/osd_text_ram.sv
source/osd_glyph_render.sv
source/osd_mixer.sv
source/osd_injection.sv
verification/osd_clk_gen.sv
verification/osd_tb.sv

// ==== include/osd_font.svh ====
// 8x8 glyphs for the hex digits 0 to F, indexed by char code and then by row
// rows are written with the leftmost pixel in bit 7, which is easy to read
// glyph_row in osd_pkg mirrors them for the renderer
`ifndef OSD_FONT_SVH
`define OSD_FONT_SVH

localparam logic [7:0] OSD_FONT [0:15][0:7] = '{
  // 0 to 3
  '{8'h3C, 8'h66, 8'h6E, 8'h76, 8'h66, 8'h66, 8'h3C, 8'h00},
  '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
  '{8'h3C, 8'h66, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E, 8'h00},
  '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
  // 4 to 7
  '{8'h0C, 8'h1C, 8'h3C, 8'h6C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
  '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
  '{8'h3C, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h66, 8'h3C, 8'h00},
  '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
  // 8 to B
  '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
  '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h0C, 8'h38, 8'h00},
  '{8'h18, 8'h3C, 8'h66, 8'h66, 8'h7E, 8'h66, 8'h66, 8'h00},
  '{8'h7C, 8'h66, 8'h66, 8'h7C, 8'h66, 8'h66, 8'h7C, 8'h00},
  // C to F
  '{8'h3C, 8'h66, 8'h60, 8'h60, 8'h60, 8'h66, 8'h3C, 8'h00},
  '{8'h78, 8'h6C, 8'h66, 8'h66, 8'h66, 8'h6C, 8'h78, 8'h00},
  '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h7E, 8'h00},
  '{8'h7E, 8'h60, 8'h60, 8'h7C, 8'h60, 8'h60, 8'h60, 8'h00}
};

`endif

// ==== run.sh ====
#!/bin/sh
# compile the OSD testbench with Verilator and run it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module osd_tb -f files.f -o osd_tb_sim

./obj_dir/osd_tb_sim

// ==== source/osd_glyph_render.sv ====
// combinational glyph lookup on the cell coming out of the text RAM
// the glyph position is delayed here by one cycle to line up with the RAM output
`timescale 1ns/1ps

module osd_glyph_render (
  input  logic                            VCLK,
  input  logic                            nVRST,
  input  osd_pkg::cell_t                  cell_i,
  input  logic [2:0]                      glyph_row_i,
  input  logic [2:0]                      glyph_col_i,
  output logic                            px_on_o,
  output logic [3*osd_pkg::COLOR_W-1:0]   txt_rgb_o
);
  import osd_pkg::*;

  logic [2:0]        row_q;
  logic [2:0]        col_q;
  logic [FONT_W-1:0] row_bits;

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      row_q <= '0;
      col_q <= '0;
    end else begin
      row_q <= glyph_row_i;
      col_q <= glyph_col_i;
    end
  end

  ////////////////////////////////////////
  // font and palette lookup

  assign row_bits = glyph_row(cell_i.code, row_q);

  // a cell with colour NONE never draws, whatever the glyph says
  assign px_on_o   = row_bits[col_q] && (cell_i.color != FC_NONE);
  assign txt_rgb_o = font_rgb(cell_i.color);

endmodule

// ==== source/osd_injection.sv ====
// OSD text overlay on a pixel stream, three cycles from input to output
// single clock domain, the Wishbone slave runs on VCLK as well
// the window and text origin are fixed by parameters at build time
`timescale 1ns/1ps

module osd_injection #(
  parameter int WIN_HSTART = 16,
  parameter int WIN_HSTOP  = 176,
  parameter int WIN_VSTART = 8,
  parameter int WIN_VSTOP  = 52,
  parameter int TXT_HSTART = 24,
  parameter int TXT_VSTART = 12
) (
  input  logic           VCLK,
  input  logic           nVRST,
  input  osd_pkg::vpix_t vpix_i,
  input  logic           valid_i,
  input  logic           wb_cyc_i,
  input  logic           wb_stb_i,
  input  logic           wb_we_i,
  input  logic [6:0]     wb_adr_i,
  input  logic [7:0]     wb_dat_i,
  output logic [7:0]     wb_dat_o,
  output logic           wb_ack_o,
  output osd_pkg::vpix_t vpix_o,
  output logic           valid_o
);
  import osd_pkg::*;

  osd_ctrl_t           ctrl;
  logic                cell_we;
  cell_addr_t          cell_adr;
  cell_t               cell_wdat;
  cell_t               cell_bus;
  cell_t               cell_disp;
  raster_t             rast;
  logic                px_on;
  logic [3*COLOR_W-1:0] txt_rgb;

  osd_wb_regs osd_wb_regs_i (
    .VCLK      (VCLK),
    .nVRST     (nVRST),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .ctrl_o    (ctrl),
    .cell_we_o (cell_we),
    .cell_adr_o(cell_adr),
    .cell_dat_o(cell_wdat),
    .cell_rd_i (cell_bus)
  );

  ////////////////////////////////////////
  // video pipeline

  osd_raster #(
    .WIN_HSTART(WIN_HSTART),
    .WIN_HSTOP (WIN_HSTOP),
    .WIN_VSTART(WIN_VSTART),
    .WIN_VSTOP (WIN_VSTOP),
    .TXT_HSTART(TXT_HSTART),
    .TXT_VSTART(TXT_VSTART)
  ) osd_raster_i (
    .VCLK   (VCLK),
    .nVRST  (nVRST),
    .vpix_i (vpix_i),
    .valid_i(valid_i),
    .rast_o (rast)
  );

  osd_text_ram osd_text_ram_i (
    .VCLK  (VCLK),
    .we_i  (cell_we),
    .wadr_i(cell_adr),
    .wdat_i(cell_wdat),
    .radr_i(rast.cell_adr),
    .rdat_o(cell_disp),
    .badr_i(cell_adr),
    .bdat_o(cell_bus)
  );

  osd_glyph_render osd_glyph_render_i (
    .VCLK       (VCLK),
    .nVRST      (nVRST),
    .cell_i     (cell_disp),
    .glyph_row_i(rast.glyph_row),
    .glyph_col_i(rast.glyph_col),
    .px_on_o    (px_on),
    .txt_rgb_o  (txt_rgb)
  );

  osd_mixer osd_mixer_i (
    .VCLK     (VCLK),
    .nVRST    (nVRST),
    .rast_i   (rast),
    .ctrl_i   (ctrl),
    .px_on_i  (px_on),
    .txt_rgb_i(txt_rgb),
    .vpix_o   (vpix_o),
    .valid_o  (valid_o)
  );

endmodule

// ==== source/osd_mixer.sv ====
// last pipeline stage, delays the raster result to match the RAM
// syncs always pass through, colours are replaced only inside the window
`timescale 1ns/1ps

module osd_mixer (
  input  logic                          VCLK,
  input  logic                          nVRST,
  input  osd_pkg::raster_t              rast_i,
  input  osd_pkg::osd_ctrl_t            ctrl_i,
  input  logic                          px_on_i,
  input  logic [3*osd_pkg::COLOR_W-1:0] txt_rgb_i,
  output osd_pkg::vpix_t                vpix_o,
  output logic                          valid_o
);
  import osd_pkg::*;

  localparam int KEEP_W = COLOR_W - TINT_W;

  raster_t             rast_q;
  vpix_t               pix_d;
  logic [3*TINT_W-1:0] tint;

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      rast_q <= '0;
    end else begin
      rast_q <= rast_i;
    end
  end

  assign tint = bg_tint(ctrl_i.bg_sel);

  ////////////////////////////////////////
  // colour select

  always_comb begin
    pix_d = rast_q.pix;
    if (ctrl_i.show_osd && rast_q.in_window) begin
      if (rast_q.in_text && px_on_i) begin
        {pix_d.red, pix_d.green, pix_d.blue} = txt_rgb_i;
      end else begin
        // tint on top, low bits of the source show through
        pix_d.red   = {tint[3*TINT_W-1 -: TINT_W], rast_q.pix.red[KEEP_W-1:0]};
        pix_d.green = {tint[2*TINT_W-1 -: TINT_W], rast_q.pix.green[KEEP_W-1:0]};
        pix_d.blue  = {tint[TINT_W-1:0], rast_q.pix.blue[KEEP_W-1:0]};
      end
    end
  end

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= rast_q.valid;
    end
  end

  always_ff @(posedge VCLK) begin
    vpix_o <= pix_d;
  end

endmodule

// ==== source/osd_pkg.sv ====
// shared types, geometry constants and palette lookups of the OSD
// the glyph table comes from osd_font.svh, so include/ must be on the include path
// glyph row and column fields are 3 bits and assume 8x8 glyphs
package osd_pkg;

  localparam int COLOR_W  = 8;
  localparam int TINT_W   = 3;
  localparam int FONT_W   = 8;
  localparam int FONT_H   = 8;
  localparam int TXT_COLS = 16;
  localparam int TXT_ROWS = 4;
  localparam int CNT_W    = 11;

  `include "osd_font.svh"

  ////////////////////////////////////////
  // video and text types

  // 26 bits, syncs on top
  typedef struct packed {
    logic               nvsync;
    logic               nhsync;
    logic [COLOR_W-1:0] red;
    logic [COLOR_W-1:0] green;
    logic [COLOR_W-1:0] blue;
  } vpix_t;

  typedef logic [3:0] char_code_t;

  // FC_NONE keeps a cell transparent
  typedef enum logic [3:0] {
    FC_NONE, FC_BLACK, FC_GREY, FC_LIGHTGREY,
    FC_WHITE, FC_RED, FC_GREEN, FC_BLUE,
    FC_YELLOW, FC_CYAN, FC_MAGENTA, FC_DARKORANGE,
    FC_TOMATO, FC_DARKMAGENTA, FC_NAVAJOWHITE, FC_DARKGOLD
  } font_color_e;

  typedef enum logic [1:0] {
    BG_DARKBLUE, BG_WHITE, BG_GREY, BG_BLACK
  } bg_color_e;

  // bus byte layout of a cell: colour in [7:4], code in [3:0]
  typedef struct packed {
    font_color_e color;
    char_code_t  code;
  } cell_t;

  // row * 16 + column
  typedef logic [5:0] cell_addr_t;

  // control register at bus address 64, bit 2 show_osd, bits 1:0 background
  typedef struct packed {
    logic      show_osd;
    bg_color_e bg_sel;
  } osd_ctrl_t;

  typedef struct packed {
    vpix_t      pix;
    logic       valid;
    logic       in_window;
    logic       in_text;
    cell_addr_t cell_adr;
    logic [2:0] glyph_row;
    logic [2:0] glyph_col;
  } raster_t;

  ////////////////////////////////////////
  // palette and font lookups

  function automatic logic [3*COLOR_W-1:0] font_rgb(input font_color_e color);
    unique case (color)
      FC_NONE:        return 24'h000000;
      FC_BLACK:       return 24'h000000;
      FC_GREY:        return 24'h808080;
      FC_LIGHTGREY:   return 24'hD3D3D3;
      FC_WHITE:       return 24'hFFFFFF;
      FC_RED:         return 24'hFF0000;
      FC_GREEN:       return 24'h00FF00;
      FC_BLUE:        return 24'h0000FF;
      FC_YELLOW:      return 24'hFFFF00;
      FC_CYAN:        return 24'h00FFFF;
      FC_MAGENTA:     return 24'hFF00FF;
      FC_DARKORANGE:  return 24'hFF8C00;
      FC_TOMATO:      return 24'hFF6347;
      FC_DARKMAGENTA: return 24'h8B008B;
      FC_NAVAJOWHITE: return 24'hFFDEAD;
      FC_DARKGOLD:    return 24'hB8860B;
    endcase
  endfunction

  // three bits per channel, red on top
  function automatic logic [3*TINT_W-1:0] bg_tint(input bg_color_e bg);
    unique case (bg)
      BG_DARKBLUE: return {3'd0, 3'd0, 3'd3};
      BG_WHITE:    return {3'd7, 3'd7, 3'd7};
      BG_GREY:     return {3'd3, 3'd3, 3'd3};
      BG_BLACK:    return {3'd0, 3'd0, 3'd0};
    endcase
  endfunction

  // bit 0 of the result is the leftmost pixel
  function automatic logic [FONT_W-1:0] glyph_row(input char_code_t code,
                                                  input logic [2:0] row);
    logic [FONT_W-1:0] msb_left;
    logic [FONT_W-1:0] lsb_left;
    msb_left = OSD_FONT[code][row];
    for (int i = 0; i < FONT_W; i++) begin
      lsb_left[i] = msb_left[FONT_W-1-i];
    end
    return lsb_left;
  endfunction

endpackage

// ==== source/osd_raster.sv ====
// counts valid pixels between falling sync edges in one register stage
// invalid pixels keep the position of the last valid one
// the text area is clipped at the window edge
`timescale 1ns/1ps

module osd_raster #(
  parameter int WIN_HSTART = 16,
  parameter int WIN_HSTOP  = 176,
  parameter int WIN_VSTART = 8,
  parameter int WIN_VSTOP  = 52,
  parameter int TXT_HSTART = 24,
  parameter int TXT_VSTART = 12
) (
  input  logic             VCLK,
  input  logic             nVRST,
  input  osd_pkg::vpix_t   vpix_i,
  input  logic             valid_i,
  output osd_pkg::raster_t rast_o
);
  import osd_pkg::*;

  localparam int TXT_HSTOP = TXT_HSTART + TXT_COLS * FONT_W;
  localparam int TXT_VSTOP = TXT_VSTART + TXT_ROWS * FONT_H;
  localparam int GX_W      = $clog2(FONT_W);
  localparam int GY_W      = $clog2(FONT_H);
  localparam int COL_W     = $clog2(TXT_COLS);
  localparam int ROW_W     = $clog2(TXT_ROWS);

  // text area bounds after clipping to the window
  localparam int CLIP_HSTART = (TXT_HSTART > WIN_HSTART) ? TXT_HSTART : WIN_HSTART;
  localparam int CLIP_HSTOP  = (TXT_HSTOP < WIN_HSTOP) ? TXT_HSTOP : WIN_HSTOP;
  localparam int CLIP_VSTART = (TXT_VSTART > WIN_VSTART) ? TXT_VSTART : WIN_VSTART;
  localparam int CLIP_VSTOP  = (TXT_VSTOP < WIN_VSTOP) ? TXT_VSTOP : WIN_VSTOP;

  logic             nhsync_pre;
  logic             nvsync_pre;
  logic             neg_h;
  logic             neg_v;
  logic [CNT_W-1:0] hcnt_q;
  logic [CNT_W-1:0] vcnt_q;
  logic [CNT_W-1:0] hcnt_cur;
  logic [CNT_W-1:0] vcnt_cur;
  logic [CNT_W-1:0] txt_h;
  logic [CNT_W-1:0] txt_v;
  logic             win_hit;
  logic             txt_hit;
  logic             valid_q;
  logic             win_q;
  logic             txt_q;
  vpix_t            pix_q;
  cell_addr_t       cell_adr_q;
  logic [2:0]       grow_q;
  logic [2:0]       gcol_q;

  assign neg_h = valid_i & nhsync_pre & ~vpix_i.nhsync;
  assign neg_v = valid_i & nvsync_pre & ~vpix_i.nvsync;

  // position of the current pixel where a vsync edge wins over the line increment
  always_comb begin
    hcnt_cur = hcnt_q;
    vcnt_cur = vcnt_q;
    if (valid_i) begin
      if (neg_h) begin
        hcnt_cur = '0;
        vcnt_cur = vcnt_q + 1'b1;
      end else begin
        hcnt_cur = hcnt_q + 1'b1;
      end
      if (neg_v) begin
        vcnt_cur = '0;
      end
    end
  end

  assign win_hit = (hcnt_cur >= CNT_W'(WIN_HSTART)) && (hcnt_cur < CNT_W'(WIN_HSTOP)) &&
                   (vcnt_cur >= CNT_W'(WIN_VSTART)) && (vcnt_cur < CNT_W'(WIN_VSTOP));
  assign txt_hit = (hcnt_cur >= CNT_W'(CLIP_HSTART)) && (hcnt_cur < CNT_W'(CLIP_HSTOP)) &&
                   (vcnt_cur >= CNT_W'(CLIP_VSTART)) && (vcnt_cur < CNT_W'(CLIP_VSTOP));

  // offsets into the text area are only meaningful while txt_hit
  assign txt_h = hcnt_cur - CNT_W'(TXT_HSTART);
  assign txt_v = vcnt_cur - CNT_W'(TXT_VSTART);

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      nhsync_pre <= 1'b0;
      nvsync_pre <= 1'b0;
      hcnt_q     <= '0;
      vcnt_q     <= '0;
      valid_q    <= 1'b0;
      win_q      <= 1'b0;
      txt_q      <= 1'b0;
    end else begin
      if (valid_i) begin
        nhsync_pre <= vpix_i.nhsync;
        nvsync_pre <= vpix_i.nvsync;
        hcnt_q     <= hcnt_cur;
        vcnt_q     <= vcnt_cur;
      end
      valid_q <= valid_i;
      win_q   <= win_hit;
      txt_q   <= txt_hit;
    end
  end

  always_ff @(posedge VCLK) begin
    pix_q      <= vpix_i;
    cell_adr_q <= {txt_v[GY_W +: ROW_W], txt_h[GX_W +: COL_W]};
    grow_q     <= txt_v[GY_W-1:0];
    gcol_q     <= txt_h[GX_W-1:0];
  end

  always_comb begin
    rast_o.pix       = pix_q;
    rast_o.valid     = valid_q;
    rast_o.in_window = win_q;
    rast_o.in_text   = txt_q;
    rast_o.cell_adr  = cell_adr_q;
    rast_o.glyph_row = grow_q;
    rast_o.glyph_col = gcol_q;
  end

  a_text_in_window: assert property (@(posedge VCLK) disable iff (!nVRST)
    rast_o.in_text |-> rast_o.in_window);

endmodule

// ==== source/osd_text_ram.sv ====
// 64-cell text memory, no reset on the contents
// display read is registered, bus read is asynchronous
// a write and a display read of the same cell in one cycle return the old cell
`timescale 1ns/1ps

module osd_text_ram (
  input  logic                VCLK,
  input  logic                we_i,
  input  osd_pkg::cell_addr_t wadr_i,
  input  osd_pkg::cell_t      wdat_i,
  input  osd_pkg::cell_addr_t radr_i,
  output osd_pkg::cell_t      rdat_o,
  input  osd_pkg::cell_addr_t badr_i,
  output osd_pkg::cell_t      bdat_o
);
  import osd_pkg::*;

  localparam int DEPTH = TXT_COLS * TXT_ROWS;

  cell_t mem [DEPTH];

  ////////////////////////////////////////
  // bus write and display read

  always_ff @(posedge VCLK) begin
    if (we_i) begin
      mem[wadr_i] <= wdat_i;
    end
    rdat_o <= mem[radr_i];
  end

  // bus side read, sampled by the slave together with the request
  assign bdat_o = mem[badr_i];

endmodule

// ==== source/osd_wb_regs.sv ====
// Wishbone classic slave with a one-cycle ack and single-beat transfers
// addresses 0..63 are cells and 64 is the control register while the rest read as 0
// read data is sampled with the request and held while ack is high
`timescale 1ns/1ps

module osd_wb_regs (
  input  logic                VCLK,
  input  logic                nVRST,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [6:0]          wb_adr_i,
  input  logic [7:0]          wb_dat_i,
  output logic [7:0]          wb_dat_o,
  output logic                wb_ack_o,
  output osd_pkg::osd_ctrl_t  ctrl_o,
  output logic                cell_we_o,
  output osd_pkg::cell_addr_t cell_adr_o,
  output osd_pkg::cell_t      cell_dat_o,
  input  osd_pkg::cell_t      cell_rd_i
);
  import osd_pkg::*;

  localparam logic [6:0] CTRL_ADR = 7'd64;

  logic      req;
  logic      cell_sel;
  logic      ctrl_sel;
  logic [7:0] rd_data;
  osd_ctrl_t ctrl_q;

  // a request is taken only while no ack is out, so a held stb starts a new one
  assign req      = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign cell_sel = ~wb_adr_i[6];
  assign ctrl_sel = (wb_adr_i == CTRL_ADR);

  assign cell_we_o  = req & wb_we_i & cell_sel;
  assign cell_adr_o = wb_adr_i[5:0];
  assign cell_dat_o = cell_t'(wb_dat_i);
  assign ctrl_o     = ctrl_q;

  always_comb begin
    rd_data = '0;
    if (cell_sel) begin
      rd_data = cell_rd_i;
    end else if (ctrl_sel) begin
      rd_data = 8'(ctrl_q);
    end
  end

  always_ff @(posedge VCLK or negedge nVRST) begin
    if (!nVRST) begin
      wb_ack_o        <= 1'b0;
      ctrl_q.show_osd <= 1'b0;
      ctrl_q.bg_sel   <= BG_DARKBLUE;
    end else begin
      wb_ack_o <= req;
      if (req && wb_we_i && ctrl_sel) begin
        ctrl_q.show_osd <= wb_dat_i[2];
        ctrl_q.bg_sel   <= bg_color_e'(wb_dat_i[1:0]);
      end
    end
  end

  always_ff @(posedge VCLK) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  // ack only goes out while the master still holds cyc and stb
  a_ack_needs_req: assert property (@(posedge VCLK) disable iff (!nVRST)
    $rose(wb_ack_o) |-> wb_cyc_i && wb_stb_i);

endmodule

// ==== verification/osd_clk_gen.sv ====
// clock and reset for the OSD testbench
// reset is held for RST_CYCLES rising edges and released on a falling edge
// rst_req_i sampled high on a falling edge starts a new reset pulse
`timescale 1ns/1ps

module osd_clk_gen #(
  parameter real PERIOD_NS  = 4.0,
  parameter int  RST_CYCLES = 8
) (
  input  logic rst_req_i,
  output logic VCLK,
  output logic nVRST
);

  int unsigned rst_cnt = RST_CYCLES;

  initial begin
    VCLK = 1'b0;
    forever #(PERIOD_NS / 2.0) VCLK = ~VCLK;
  end

  always @(negedge VCLK) begin
    if (rst_req_i) begin
      rst_cnt <= RST_CYCLES;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  assign nVRST = (rst_cnt == 0);

endmodule

// ==== verification/osd_tb.sv ====
// testbench for osd_injection with its default window and text origin
// the reference model predicts every output pixel three cycles after its input
// cell contents are unknown until written, so text checks start after the writes
// stops at the first mismatch
`timescale 1ns/1ps

module osd_tb;
  import osd_pkg::*;

  localparam int WIN_HSTART = 16;
  localparam int WIN_HSTOP  = 176;
  localparam int WIN_VSTART = 8;
  localparam int WIN_VSTOP  = 52;
  localparam int TXT_HSTART = 24;
  localparam int TXT_VSTART = 12;

  localparam int LINE_PIX    = 200;
  localparam int FRAME_LINES = 60;
  localparam int HS_PIX      = 4;
  localparam int VS_LINES    = 2;
  localparam int PIPE_LAT    = 3;
  localparam int ACK_TIMEOUT = 8;
  localparam int RST_TIMEOUT = 40;

  localparam logic [6:0]  CTRL_ADR = 7'd64;
  localparam logic [31:0] SEED     = 32'hb4d9394b;

  // expected output of one pipeline slot
  typedef struct packed {
    vpix_t pix;
    logic  valid;
  } exp_t;

  logic       VCLK;
  logic       nVRST;
  logic       rst_req;
  vpix_t      vpix_i;
  logic       valid_i;
  logic       wb_cyc_i;
  logic       wb_stb_i;
  logic       wb_we_i;
  logic [6:0] wb_adr_i;
  logic [7:0] wb_dat_i;
  logic [7:0] wb_dat_o;
  logic       wb_ack_o;
  vpix_t      vpix_o;
  logic       valid_o;

  logic [31:0] lfsr_q = SEED;
  string       test_name;
  exp_t        exp_q [$];

  // reference model state
  int        m_h;
  int        m_v;
  logic      m_prev_h;
  logic      m_prev_v;
  osd_ctrl_t m_ctrl;
  cell_t     m_cells [64];

  osd_clk_gen #(
    .PERIOD_NS (4.0),
    .RST_CYCLES(8)
  ) osd_clk_gen_i (
    .rst_req_i(rst_req),
    .VCLK     (VCLK),
    .nVRST    (nVRST)
  );

  osd_injection #(
    .WIN_HSTART(WIN_HSTART),
    .WIN_HSTOP (WIN_HSTOP),
    .WIN_VSTART(WIN_VSTART),
    .WIN_VSTOP (WIN_VSTOP),
    .TXT_HSTART(TXT_HSTART),
    .TXT_VSTART(TXT_VSTART)
  ) osd_injection_i (
    .VCLK    (VCLK),
    .nVRST   (nVRST),
    .vpix_i  (vpix_i),
    .valid_i (valid_i),
    .wb_cyc_i(wb_cyc_i),
    .wb_stb_i(wb_stb_i),
    .wb_we_i (wb_we_i),
    .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i),
    .wb_dat_o(wb_dat_o),
    .wb_ack_o(wb_ack_o),
    .vpix_o  (vpix_o),
    .valid_o (valid_o)
  );

  ////////////////////////////////////////
  // random numbers and error handling

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_pix(input string name, input vpix_t exp, input vpix_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cell(input string name, input cell_t exp, input cell_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ctrl(input string name, input osd_ctrl_t exp, input osd_ctrl_t act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // reference model

  task automatic model_reset();
    m_h             = 0;
    m_v             = 0;
    m_prev_h        = 1'b0;
    m_prev_v        = 1'b0;
    m_ctrl.show_osd = 1'b0;
    m_ctrl.bg_sel   = BG_DARKBLUE;
  endtask

  // invalid pixels keep the last valid position
  function automatic exp_t predict(input vpix_t px, input logic vld);
    exp_t       e;
    logic       in_win;
    logic       in_txt;
    logic       lit;
    int         tx;
    int         ty;
    cell_t      c;
    logic [5:0] ci;
    logic [2:0] gr;
    logic [2:0] gc;
    logic [7:0] bits;
    logic [8:0] tint;
    if (vld) begin
      if (m_prev_h && !px.nhsync) begin
        m_h = 0;
        m_v = m_v + 1;
      end else begin
        m_h = m_h + 1;
      end
      if (m_prev_v && !px.nvsync) begin
        m_v = 0;
      end
      m_prev_h = px.nhsync;
      m_prev_v = px.nvsync;
    end
    in_win = (m_h >= WIN_HSTART) && (m_h < WIN_HSTOP) &&
             (m_v >= WIN_VSTART) && (m_v < WIN_VSTOP);
    in_txt = in_win && (m_h >= TXT_HSTART) && (m_h < TXT_HSTART + TXT_COLS * FONT_W) &&
             (m_v >= TXT_VSTART) && (m_v < TXT_VSTART + TXT_ROWS * FONT_H);
    e.pix   = px;
    e.valid = vld;
    if (m_ctrl.show_osd && in_win) begin
      lit = 1'b0;
      c   = '0;
      if (in_txt) begin
        tx   = m_h - TXT_HSTART;
        ty   = m_v - TXT_VSTART;
        ci   = 6'((ty / FONT_H) * TXT_COLS + tx / FONT_W);
        gr   = 3'(ty % FONT_H);
        gc   = 3'(tx % FONT_W);
        c    = m_cells[ci];
        // font rows hold the leftmost pixel in bit 7
        bits = OSD_FONT[c.code][gr];
        lit  = (c.color != FC_NONE) && bits[3'd7 - gc];
      end
      if (lit) begin
        {e.pix.red, e.pix.green, e.pix.blue} = font_rgb(c.color);
      end else begin
        tint = bg_tint(m_ctrl.bg_sel);
        e.pix.red[7:5]   = tint[8:6];
        e.pix.green[7:5] = tint[5:3];
        e.pix.blue[7:5]  = tint[2:0];
      end
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // video stimulus

  // one pixel per cycle, output compared three cycles later
  task automatic video_step(input vpix_t px, input logic vld);
    exp_t e;
    @(posedge VCLK);
    vpix_i  <= px;
    valid_i <= vld;
    exp_q.push_back(predict(px, vld));
    @(negedge VCLK);
    if (exp_q.size() > PIPE_LAT) begin
      e = exp_q.pop_front();
      check_valid(test_name, e.valid, valid_o);
      check_pix(test_name, e.pix, vpix_o);
    end
  endtask

  task automatic hold_video();
    @(posedge VCLK);
    valid_i <= 1'b0;
    exp_q.delete();
  endtask

  // nvsync is low from pixel vs_from to the end of the line
  task automatic send_line(input int vs_from);
    logic [31:0] rb;
    vpix_t       px;
    for (int p = 0; p < LINE_PIX; p++) begin
      rb = rand_bits(2);
      if (rb[1:0] == 2'b00) begin
        rb = rand_bits(26);
        px = vpix_t'(rb[25:0]);
        video_step(px, 1'b0);
      end
      rb        = rand_bits(24);
      px.nvsync = (p < vs_from);
      px.nhsync = (p >= HS_PIX);
      {px.red, px.green, px.blue} = rb[23:0];
      video_step(px, 1'b1);
    end
  endtask

  task automatic send_frame(input int lines);
    for (int l = 0; l < lines; l++) begin
      send_line((l < VS_LINES) ? 0 : LINE_PIX);
    end
  endtask

  ////////////////////////////////////////
  // Wishbone master

  task automatic wb_transfer(input logic we, input logic [6:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
    logic acked;
    @(posedge VCLK);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdat;
    acked = 1'b0;
    for (int t = 0; t < ACK_TIMEOUT && !acked; t++) begin
      @(negedge VCLK);
      acked = wb_ack_o;
    end
    if (!acked) begin
      $display("ERROR: no Wishbone ack for address %0d within %0d cycles", adr, ACK_TIMEOUT);
      abort_run();
    end
    rdat = wb_dat_o;
    @(posedge VCLK);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [6:0] adr, input logic [7:0] dat);
    logic [7:0] unused;
    wb_transfer(1'b1, adr, dat, unused);
    if (adr == CTRL_ADR) begin
      m_ctrl = osd_ctrl_t'(dat[2:0]);
    end else if (adr < CTRL_ADR) begin
      m_cells[adr[5:0]] = cell_t'(dat);
    end
  endtask

  task automatic wb_read(input logic [6:0] adr, output logic [7:0] dat);
    wb_transfer(1'b0, adr, 8'h00, dat);
  endtask

  task automatic wait_reset_release();
    for (int t = 0; t < RST_TIMEOUT && !nVRST; t++) begin
      @(negedge VCLK);
    end
    if (!nVRST) begin
      $display("ERROR: reset still active after %0d cycles", RST_TIMEOUT);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] rb;
    logic [7:0]  rd;
    vpix_i   = '0;
    valid_i  = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    rst_req  = 1'b0;
    model_reset();
    wait_reset_release();

    test_name = "pass-through";
    send_frame(FRAME_LINES);
    send_frame(FRAME_LINES);
    hold_video();

    test_name = "bus readback";
    for (int i = 0; i < 64; i++) begin
      rb = rand_bits(8);
      wb_write(7'(i), rb[7:0]);
    end
    for (int i = 0; i < 64; i++) begin
      wb_read(7'(i), rd);
      check_cell(test_name, m_cells[6'(i)], cell_t'(rd));
    end
    // unmapped address, write dropped and read as zero
    wb_write(7'd100, 8'hA5);
    wb_read(7'd100, rd);
    check_cell(test_name, cell_t'(8'h00), cell_t'(rd));

    // transparent cells leave only the tint
    for (int i = 0; i < 64; i++) begin
      rb = rand_bits(4);
      wb_write(7'(i), {4'h0, rb[3:0]});
    end
    for (int b = 0; b < 4; b++) begin
      hold_video();
      test_name = $sformatf("tint bg %0d", b);
      wb_write(CTRL_ADR, {5'b0, 1'b1, 2'(b)});
      wb_read(CTRL_ADR, rd);
      check_ctrl(test_name, m_ctrl, osd_ctrl_t'(rd[2:0]));
      send_frame(FRAME_LINES);
    end
    hold_video();

    test_name = "text frame";
    for (int i = 0; i < 64; i++) begin
      rb = rand_bits(8);
      wb_write(7'(i), rb[7:0]);
    end
    rb = rand_bits(2);
    wb_write(CTRL_ADR, {5'b0, 1'b1, rb[1:0]});
    send_frame(FRAME_LINES);

    // vsync falls halfway through a line, then a normal frame follows
    test_name = "mid-run vsync";
    send_frame(25);
    send_line(LINE_PIX / 2);
    for (int l = 0; l < 30; l++) begin
      send_line(LINE_PIX);
    end
    send_frame(FRAME_LINES);
    send_frame(30);

    // reset hits with a bus request pending and valid pixels in flight
    test_name = "reset mid-frame";
    @(posedge VCLK);
    rst_req  <= 1'b1;
    valid_i  <= 1'b0;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= CTRL_ADR;
    exp_q.delete();
    @(posedge VCLK);
    rst_req  <= 1'b0;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    @(negedge VCLK);
    check_valid(test_name, 1'b0, valid_o);
    check_valid(test_name, 1'b0, wb_ack_o);
    wait_reset_release();
    model_reset();
    wb_read(CTRL_ADR, rd);
    check_ctrl(test_name, m_ctrl, osd_ctrl_t'(rd[2:0]));
    test_name = "pass-through after reset";
    send_frame(FRAME_LINES);
    send_frame(FRAME_LINES);

    $display("All tests passed!");
    $finish;
  end

endmodule
